// File: logic/biu_ahb3lite.sv
/* AHB3-Lite master BIU, address phase, data-phase register,
   wait state handling and two-cycle error response */
`timescale 1ns/100ps

module biu_ahb3lite
  import biu_pkg::*;
(
  input  logic            HCLK,
  input  logic            rst_n_i,

  // Strobe/acknowledge side
  input  logic            biu_stb_i,
  input  biu_req_t        biu_req_i,
  output logic            biu_stb_ack_o,
  output logic            biu_ack_o,
  output logic            biu_err_o,
  output logic [XLEN-1:0] biu_q_o,

  // AHB side
  output ahb_m2s_t        ahb_o,
  input  ahb_s2m_t        ahb_i
);

  ////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////

  // Transfer in its data phase
  typedef struct packed {
    logic            valid;
    logic            we;
    logic [XLEN-1:0] d;
  } dphase_t;

  dphase_t dp;

  // First cycle of a slave error response
  logic    err_first;

  // Address phase driven this cycle
  logic    addr_phase;

  // Data phase ends on this edge
  logic    dp_done;

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  // Error shows as HRESP high with HREADY low first
  assign err_first = dp.valid & ~ahb_i.hready & (ahb_i.hresp == HRESP_ERROR);

  // NONSEQ while strobed, dropped to IDLE on error cycle one
  assign addr_phase = biu_stb_i & ~err_first;

  // Hand-off once the slave takes the address
  assign biu_stb_ack_o = addr_phase & ahb_i.hready;

  always_comb
  begin
    ahb_o.hsel      = addr_phase;
    ahb_o.haddr     = biu_req_i.adr;
    ahb_o.hwrite    = biu_req_i.we;
    ahb_o.hsize     = biu_req_i.size;
    ahb_o.hburst    = HBURST_SINGLE;
    ahb_o.hprot     = HPROT_DATA_PRIV;
    ahb_o.htrans    = addr_phase ? HTRANS_NONSEQ : HTRANS_IDLE;
    ahb_o.hmastlock = addr_phase & biu_req_i.lock;

    // Write data belongs to the previous address phase
    ahb_o.hwdata    = dp.d;
  end

  ////////////////////////////////////////////////////////////
  // Data phase register
  ////////////////////////////////////////////////////////////

  // Loaded whenever HREADY closes the current phase,
  // so data phase and next address phase overlap
  always_ff @(posedge HCLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dp <= '0;
    end
    else if (ahb_i.hready)
    begin
      dp.valid <= biu_stb_ack_o;
      dp.we    <= biu_req_i.we;
      dp.d     <= biu_req_i.d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////

  // Last HREADY of a valid data phase
  assign dp_done = dp.valid & ahb_i.hready;

  // Single-cycle pulses, one cycle after the final HREADY
  always_ff @(posedge HCLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      biu_ack_o <= 1'b0;
      biu_err_o <= 1'b0;
    end
    else
    begin
      biu_ack_o <= dp_done & (ahb_i.hresp == HRESP_OKAY);
      biu_err_o <= dp_done & (ahb_i.hresp == HRESP_ERROR);
    end
  end

  // Read data capture
  always_ff @(posedge HCLK)
  begin
    if (dp_done & ~dp.we)
      biu_q_o <= ahb_i.hrdata;
  end

endmodule

// File: logic/biu_pkg.sv
/* Widths, AHB3-Lite encodings, transfer enums and the request
   and bus structs shared by the data memory path */
package biu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // CPU data and address width
  localparam int XLEN = 32;
  localparam int ALEN = 32;

  // AHB field widths
  localparam int HSIZE_SIZE  = 3;
  localparam int HTRANS_SIZE = 2;
  localparam int HBURST_SIZE = 3;
  localparam int HPROT_SIZE  = 4;

  ////////////////////////////////////////////////////////////
  // AHB constants
  ////////////////////////////////////////////////////////////

  // Only single transfers are issued
  localparam logic [HBURST_SIZE-1:0] HBURST_SINGLE = 3'b000;

  // Data access, privileged, non-bufferable, non-cacheable
  localparam logic [HPROT_SIZE-1:0] HPROT_DATA_PRIV = 4'b0011;

  // Slave response codes
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  // Transfer size, same codes as HSIZE
  typedef enum logic [HSIZE_SIZE-1:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } biu_size_t;

  // AHB transfer type
  typedef enum logic [HTRANS_SIZE-1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // CPU load/store request, write data already lane aligned
  typedef struct packed {
    logic [ALEN-1:0] adr;
    biu_size_t       size;
    logic            we;
    logic            lock;
    logic [XLEN-1:0] d;
  } dmem_req_t;

  // Controller to BIU request
  typedef struct packed {
    logic [ALEN-1:0] adr;
    biu_size_t       size;
    logic            we;
    logic            lock;
    logic [XLEN-1:0] d;
  } biu_req_t;

  // AHB master outputs
  typedef struct packed {
    logic                   hsel;
    logic [ALEN-1:0]        haddr;
    logic [XLEN-1:0]        hwdata;
    logic                   hwrite;
    logic [HSIZE_SIZE-1:0]  hsize;
    logic [HBURST_SIZE-1:0] hburst;
    logic [HPROT_SIZE-1:0]  hprot;
    htrans_t                htrans;
    logic                   hmastlock;
  } ahb_m2s_t;

  // AHB slave responses
  typedef struct packed {
    logic [XLEN-1:0] hrdata;
    logic            hready;
    logic            hresp;
  } ahb_s2m_t;

endpackage

// File: logic/dmem_ahb3lite_top.sv
/* Data memory path top level, controller and AHB3-Lite BIU */
`timescale 1ns/100ps

module dmem_ahb3lite_top
  import biu_pkg::*;
(
  input  logic            HCLK,
  input  logic            rst_n_i,

  // CPU load/store port
  input  logic            mem_req_i,
  input  dmem_req_t       mem_d_i,
  output logic            mem_gnt_o,
  output logic            mem_ack_o,
  output logic            mem_err_o,
  output logic [XLEN-1:0] mem_q_o,

  // AHB3-Lite master port
  output ahb_m2s_t        ahb_o,
  input  ahb_s2m_t        ahb_i
);

  ////////////////////////////////////////////////////////////
  // Controller to BIU wires
  ////////////////////////////////////////////////////////////

  logic            biu_stb;
  biu_req_t        biu_req;
  logic            biu_stb_ack;
  logic            biu_ack;
  logic            biu_err;
  logic [XLEN-1:0] biu_q;

  // Alignment check and in-order tracking
  dmem_ctrl u_dmem_ctrl (
    .HCLK          ( HCLK        ),
    .rst_n_i       ( rst_n_i     ),
    .mem_req_i     ( mem_req_i   ),
    .mem_d_i       ( mem_d_i     ),
    .mem_gnt_o     ( mem_gnt_o   ),
    .mem_ack_o     ( mem_ack_o   ),
    .mem_err_o     ( mem_err_o   ),
    .mem_q_o       ( mem_q_o     ),
    .biu_stb_o     ( biu_stb     ),
    .biu_req_o     ( biu_req     ),
    .biu_stb_ack_i ( biu_stb_ack ),
    .biu_ack_i     ( biu_ack     ),
    .biu_err_i     ( biu_err     ),
    .biu_q_i       ( biu_q       )
  );

  // AHB3-Lite master
  biu_ahb3lite u_biu (
    .HCLK          ( HCLK        ),
    .rst_n_i       ( rst_n_i     ),
    .biu_stb_i     ( biu_stb     ),
    .biu_req_i     ( biu_req     ),
    .biu_stb_ack_o ( biu_stb_ack ),
    .biu_ack_o     ( biu_ack     ),
    .biu_err_o     ( biu_err     ),
    .biu_q_o       ( biu_q       ),
    .ahb_o         ( ahb_o       ),
    .ahb_i         ( ahb_i       )
  );

endmodule

// File: logic/dmem_ctrl.sv
/* Data memory controller, misalignment check, two-entry in-order
   completion queue and CPU response mux */
`timescale 1ns/100ps

module dmem_ctrl
  import biu_pkg::*;
(
  input  logic            HCLK,
  input  logic            rst_n_i,

  // CPU side
  input  logic            mem_req_i,
  input  dmem_req_t       mem_d_i,
  output logic            mem_gnt_o,
  output logic            mem_ack_o,
  output logic            mem_err_o,
  output logic [XLEN-1:0] mem_q_o,

  // BIU side
  output logic            biu_stb_o,
  output biu_req_t        biu_req_o,
  input  logic            biu_stb_ack_i,
  input  logic            biu_ack_i,
  input  logic            biu_err_i,
  input  logic [XLEN-1:0] biu_q_i
);

  ////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////

  // Completion source of a queued request
  typedef enum logic {
    TAG_BUS,
    TAG_LOCAL
  } tag_t;

  logic       misaligned;
  logic       slot_free;
  logic       push;
  logic       pop;
  logic       head_local;

  // Queue occupancy and pointers
  logic [1:0] cnt;
  logic       wr_ptr;
  logic       rd_ptr;
  tag_t       tag_q [2];

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Alignment check on size and low address bits
  always_comb
  begin
    case (mem_d_i.size)
      BYTE:    misaligned = 1'b0;
      HWORD:   misaligned = mem_d_i.adr[0];
      WORD:    misaligned = |mem_d_i.adr[1:0];
      default: misaligned = 1'b1;
    endcase
  end

  // At most two requests in flight
  assign slot_free = (cnt != 2'd2);

  // Only aligned requests go to the bus
  assign biu_stb_o = mem_req_i & ~misaligned & slot_free;

  always_comb
  begin
    biu_req_o.adr  = mem_d_i.adr;
    biu_req_o.size = mem_d_i.size;
    biu_req_o.we   = mem_d_i.we;
    biu_req_o.lock = mem_d_i.lock;
    biu_req_o.d    = mem_d_i.d;
  end

  // Bus requests granted on address phase hand-off,
  // misaligned ones as soon as a slot is free
  assign mem_gnt_o = slot_free & (misaligned | biu_stb_ack_i);
  assign push      = mem_req_i & mem_gnt_o;

  ////////////////////////////////////////////////////////////
  // In-order tag queue
  ////////////////////////////////////////////////////////////

  // Local error waiting at the head
  assign head_local = (cnt != 2'd0) & (tag_q[rd_ptr] == TAG_LOCAL);

  // Head leaves on bus completion or after one cycle as local error
  assign pop = biu_ack_i | biu_err_i | head_local;

  always_ff @(posedge HCLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt    <= 2'd0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end
    else
    begin
      case ({push, pop})
        2'b10:   cnt <= cnt + 2'd1;
        2'b01:   cnt <= cnt - 2'd1;
        default: cnt <= cnt;
      endcase

      if (push)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
    end
  end

  // Tag storage, qualified by cnt
  always_ff @(posedge HCLK)
  begin
    if (push)
      tag_q[wr_ptr] <= misaligned ? TAG_LOCAL : TAG_BUS;
  end

  ////////////////////////////////////////////////////////////
  // CPU response mux
  ////////////////////////////////////////////////////////////

  // One pulse per completion, errors included
  assign mem_ack_o = head_local | biu_ack_i | biu_err_i;
  assign mem_err_o = head_local | biu_err_i;

  // No read data for a local error
  assign mem_q_o   = head_local ? '0 : biu_q_i;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the data memory path simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f src.f --top-module dmem_tb -o dmem_sim
out=$(./obj_dir/dmem_sim) || true
echo "$out"
echo "$out" | grep -q "TEST PASSED"

// File: src.f
logic/biu_pkg.sv
logic/dmem_ctrl.sv
logic/biu_ahb3lite.sv
logic/dmem_ahb3lite_top.sv
testbench/ahb_mem_slave.sv
testbench/dmem_tb.sv

// File: testbench/ahb_mem_slave.sv
/* AHB3-Lite memory slave with random wait states,
   two-cycle error response for an address region */
`timescale 1ns/100ps

module ahb_mem_slave
  import biu_pkg::*;
#(
  parameter int MEM_WORDS = 1024,
  parameter int ERR_BIT   = 12
)
(
  input  logic     HCLK,
  input  logic     rst_n_i,
  input  ahb_m2s_t ahb_i,
  output ahb_s2m_t ahb_o
);

  logic [XLEN-1:0] mem [MEM_WORDS];
  integer          seed;
  integer          waits;

  // Registered response
  logic            hready_q;
  logic            hresp_q;

  // Data phase state
  logic            dp_active;
  logic            dp_write;
  logic            dp_err;
  logic            err_first;
  logic [ALEN-1:0] dp_addr;
  biu_size_t       dp_size;
  int              wait_cnt;

  // Fill depends on the whole word index
  initial
  begin
    seed = 32'h9314_3324;
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = 32'h1F3D_0000 ^ (i * 32'h0001_0203);
  end

  function automatic logic lane_on(biu_size_t s, logic [1:0] a, int k);
    case (s)
      BYTE:    return k == int'(a);
      HWORD:   return (k / 2) == int'(a[1]);
      default: return 1'b1;
    endcase
  endfunction

  assign ahb_o = '{hrdata: mem[dp_addr[11:2]], hready: hready_q, hresp: hresp_q};

  always @(posedge HCLK or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      hready_q  <= 1'b1;
      hresp_q   <= HRESP_OKAY;
      dp_active <= 1'b0;
      dp_write  <= 1'b0;
      dp_err    <= 1'b0;
      err_first <= 1'b0;
      dp_addr   <= '0;
      dp_size   <= BYTE;
      wait_cnt  <= 0;
    end
    else if (hready_q)
    begin
      // Write completes on the final cycle of its data phase
      if (dp_active && dp_write && !dp_err)
        for (int k = 0; k < 4; k++)
          if (lane_on(dp_size, dp_addr[1:0], k))
            mem[dp_addr[11:2]][8*k +: 8] <= ahb_i.hwdata[8*k +: 8];

      if (ahb_i.hsel && ahb_i.htrans == HTRANS_NONSEQ)
      begin
        waits     = $random(seed) & 7;
        dp_active <= 1'b1;
        dp_write  <= ahb_i.hwrite;
        dp_addr   <= ahb_i.haddr;
        dp_size   <= biu_size_t'(ahb_i.hsize);
        dp_err    <= ahb_i.haddr[ERR_BIT];
        if (ahb_i.haddr[ERR_BIT])
        begin
          hready_q  <= 1'b0;
          hresp_q   <= HRESP_ERROR;
          err_first <= 1'b1;
        end
        else
        begin
          hresp_q  <= HRESP_OKAY;
          hready_q <= !(waits > 0 && waits < 4);
          wait_cnt <= (waits < 4) ? waits - 1 : 0;
        end
      end
      else
      begin
        dp_active <= 1'b0;
        hresp_q   <= HRESP_OKAY;
      end
    end
    else if (err_first)
    begin
      // Second error cycle
      err_first <= 1'b0;
      hready_q  <= 1'b1;
    end
    else if (wait_cnt == 0)
      hready_q <= 1'b1;
    else
      wait_cnt <= wait_cnt - 1;
  end

endmodule

// File: testbench/dmem_tb.sv
/* Data memory path testbench, random CPU traffic, byte mirror
   model with in-order expected responses, watchdog */
`timescale 1ns/100ps

module dmem_tb
  import biu_pkg::*;
;

  localparam int NUM_OPS   = 400;
  localparam int MEM_WORDS = 1024;
  localparam int ERR_BIT   = 12;
  localparam int MAX_LAT   = 24;

  typedef struct packed {
    logic            err;
    logic            rd;
    logic [XLEN-1:0] q;
  } exp_t;

  logic            HCLK;
  logic            rst_n_i;
  logic            mem_req_i;
  dmem_req_t       mem_d_i;
  logic            mem_gnt_o;
  logic            mem_ack_o;
  logic            mem_err_o;
  logic [XLEN-1:0] mem_q_o;
  ahb_m2s_t        ahb_o;
  ahb_s2m_t        ahb_i;

  integer          seed;
  logic [7:0]      mirror [MEM_WORDS*4];
  exp_t            exp_q [$];
  int              outstanding;
  int              aligned_cnt;
  int              nonseq_cnt;

  dmem_ahb3lite_top UUT (
    .HCLK      ( HCLK      ),
    .rst_n_i   ( rst_n_i   ),
    .mem_req_i ( mem_req_i ),
    .mem_d_i   ( mem_d_i   ),
    .mem_gnt_o ( mem_gnt_o ),
    .mem_ack_o ( mem_ack_o ),
    .mem_err_o ( mem_err_o ),
    .mem_q_o   ( mem_q_o   ),
    .ahb_o     ( ahb_o     ),
    .ahb_i     ( ahb_i     )
  );

  ahb_mem_slave #(.MEM_WORDS(MEM_WORDS), .ERR_BIT(ERR_BIT)) u_slave (
    .HCLK    ( HCLK    ),
    .rst_n_i ( rst_n_i ),
    .ahb_i   ( ahb_o   ),
    .ahb_o   ( ahb_i   )
  );

  // 40 ns clock
  always #20 HCLK = ~HCLK;

  ////////////////////////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_q(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    if (act !== exp)
      fail_now($sformatf("MISMATCH %0t mem_q_o exp %h got %h", $time, exp, act));
  endtask

  task automatic check_err(input logic exp, input logic act);
    if (act !== exp)
      fail_now($sformatf("MISMATCH %0t mem_err_o exp %b got %b", $time, exp, act));
  endtask

  // Address phase fields only as hwdata trails by one phase
  task automatic check_ahb(input ahb_m2s_t exp, input ahb_m2s_t act);
    ahb_m2s_t a;
    a        = act;
    a.hwdata = exp.hwdata;
    if (a !== exp)
      fail_now($sformatf("MISMATCH %0t ahb_o exp %h got %h", $time, exp, a));
  endtask

  task automatic check_count(input int exp, input int act);
    if (act !== exp)
      fail_now($sformatf("MISMATCH %0t nonseq_count exp %0d got %0d", $time, exp, act));
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic lane_on(biu_size_t s, logic [1:0] a, int k);
    case (s)
      BYTE:    return k == int'(a);
      HWORD:   return (k / 2) == int'(a[1]);
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic is_misaligned(biu_size_t s, logic [1:0] a);
    return (s == HWORD && a[0]) || (s == WORD && a != 2'b00);
  endfunction

  // Responses checked in order and grants recorded at the accepting edge
  always @(negedge HCLK)
  begin
    exp_t     e;
    ahb_m2s_t x;
    int       base;
    if (rst_n_i)
    begin
      if (mem_gnt_o && outstanding == 2)
        fail_now("Grant seen while two requests were outstanding");
      if (ahb_o.htrans == HTRANS_NONSEQ && ahb_i.hready)
        nonseq_cnt++;
      if (mem_ack_o)
      begin
        if (exp_q.size() == 0)
          fail_now("Acknowledge seen with no request outstanding");
        e = exp_q.pop_front();
        check_err(e.err, mem_err_o);
        if (!e.err && e.rd)
          check_q(e.q, mem_q_o);
        outstanding--;
      end
      if (mem_req_i && mem_gnt_o)
      begin
        base  = int'(mem_d_i.adr[11:2]) * 4;
        e.rd  = !mem_d_i.we;
        e.err = is_misaligned(mem_d_i.size, mem_d_i.adr[1:0]) | mem_d_i.adr[ERR_BIT];
        e.q   = {mirror[base+3], mirror[base+2], mirror[base+1], mirror[base]};
        if (!is_misaligned(mem_d_i.size, mem_d_i.adr[1:0]))
        begin
          aligned_cnt++;
          x           = '0;
          x.hsel      = 1'b1;
          x.haddr     = mem_d_i.adr;
          x.hwrite    = mem_d_i.we;
          x.hsize     = mem_d_i.size;
          x.hburst    = HBURST_SINGLE;
          x.hprot     = HPROT_DATA_PRIV;
          x.htrans    = HTRANS_NONSEQ;
          x.hmastlock = mem_d_i.lock;
          check_ahb(x, ahb_o);
        end
        if (!e.err && mem_d_i.we)
          for (int k = 0; k < 4; k++)
            if (lane_on(mem_d_i.size, mem_d_i.adr[1:0], k))
              mirror[base+k] = mem_d_i.d[8*k +: 8];
        exp_q.push_back(e);
        outstanding++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic issue(input dmem_req_t r);
    @(posedge HCLK);
    #1;
    mem_req_i = 1'b1;
    mem_d_i   = r;
    @(negedge HCLK);
    while (!mem_gnt_o)
      @(negedge HCLK);
  endtask

  task automatic go_idle();
    @(posedge HCLK);
    #1;
    mem_req_i = 1'b0;
  endtask

  function automatic dmem_req_t rand_req();
    dmem_req_t r;
    r.adr  = $random(seed) & 32'h0000_007C;
    r.d    = $random(seed);
    r.we   = ($random(seed) & 1) != 0;
    r.lock = ($random(seed) & 7) == 0;
    case ($random(seed) & 3)
      0:       r.size = BYTE;
      1:       r.size = HWORD;
      default: r.size = WORD;
    endcase
    if (r.size == BYTE)
      r.adr[1:0] = 2'($random(seed) & 3);
    else if (r.size == HWORD)
      r.adr[1] = ($random(seed) & 1) != 0;
    // Occasional misaligned or error region access
    if (r.size != BYTE && ($random(seed) & 7) == 0)
      r.adr[0] = 1'b1;
    if (($random(seed) & 15) == 0)
      r.adr[ERR_BIT] = 1'b1;
    return r;
  endfunction

  // Watchdog sized from the operation count
  initial
  begin
    #((NUM_OPS + 40) * MAX_LAT * 40);
    $display("Timeout, the DUT stopped completing requests");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    dmem_req_t r;
    seed        = 32'h9314_3324;
    HCLK        = 1'b0;
    rst_n_i     = 1'b0;
    mem_req_i   = 1'b0;
    mem_d_i     = '0;
    outstanding = 0;
    aligned_cnt = 0;
    nonseq_cnt  = 0;
    for (int i = 0; i < MEM_WORDS; i++)
      for (int k = 0; k < 4; k++)
        mirror[i*4+k] = 8'((32'h1F3D_0000 ^ (i * 32'h0001_0203)) >> (8 * k));
    repeat (3) @(posedge HCLK);
    #1;
    rst_n_i = 1'b1;

    // Quiet bus after reset
    repeat (2)
    begin
      @(negedge HCLK);
      if (mem_ack_o !== 1'b0)
        fail_now("Acknowledge seen after reset before any request");
      if (ahb_o.htrans !== HTRANS_IDLE)
        fail_now("Bus not idle after reset");
    end

    // Word writes then read back
    for (int i = 0; i < 8; i++)
      issue('{adr: i * 4, size: WORD, we: 1'b1, lock: 1'b0, d: $random(seed)});
    for (int i = 0; i < 8; i++)
      issue('{adr: i * 4, size: WORD, we: 1'b0, lock: 1'b0, d: '0});

    // Random mix of mostly back to back requests
    for (int n = 0; n < NUM_OPS; n++)
    begin
      r = rand_req();
      issue(r);
      if (($random(seed) & 7) == 0)
        go_idle();
    end
    go_idle();

    while (exp_q.size() != 0)
      @(posedge HCLK);
    check_count(aligned_cnt, nonseq_cnt);
    $display("TEST PASSED");
    $finish;
  end

endmodule
